// ==== sim.f ====
+incdir+source
source/fetch_pkg.sv
source/prefetch_ctrl.sv
source/align_buffer.sv
source/fetch_unit.sv
dv/fetch_mem_model.sv
dv/fetch_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := fetch_unit_tb
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -Mdir $(BUILD_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The log decides the result, a run that stops early has no pass line
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/fetch_unit_tb.sv ====
//////////////////////////////
// Testbench for the fetch front end
// Clock, reset, DUT and memory model, accept monitor,
// reference walk over the memory image and directed tests
//////////////////////////////

`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetch_unit_tb;

  // The wait limits of the five tests add up to about 3800 cycles with their resets
  localparam int TIMEOUT_CYCLES = 4000;

  logic                     clk;
  logic                     rst_n;
  logic                     instr_req;
  logic                     pc_set;
  logic [`FETCH_ADDR_W-1:0] branch_addr;
  logic                     bus_req;
  logic [`FETCH_ADDR_W-1:0] bus_addr;
  logic                     bus_gnt;
  logic                     bus_rvalid;
  logic [31:0]              bus_rdata;
  logic                     instr_valid;
  logic                     instr_ready;
  logic [31:0]              instr;
  logic [`FETCH_ADDR_W-1:0] instr_addr;
  logic                     instr_compressed;

  integer      seed;
  int          errors;
  int          checks;
  int          cycle_cnt;
  int          outstanding;
  logic [31:0] image [256];

  // Accepted instructions in order, filled by the monitor
  logic [31:0] got_instr [$];
  logic [31:0] got_addr [$];
  logic        got_comp [$];

  // Offer seen with ready low, which must still stand one cycle later
  logic        hold_pending;
  logic [31:0] held_instr;
  logic [31:0] held_addr;
  logic        held_comp;

  fetch_unit u_dut (
    .clk                (clk),
    .rst_n              (rst_n),
    .instr_req_i        (instr_req),
    .pc_set_i           (pc_set),
    .branch_addr_i      (branch_addr),
    .bus_req_o          (bus_req),
    .bus_addr_o         (bus_addr),
    .bus_gnt_i          (bus_gnt),
    .bus_rvalid_i       (bus_rvalid),
    .bus_rdata_i        (bus_rdata),
    .instr_valid_o      (instr_valid),
    .instr_ready_i      (instr_ready),
    .instr_o            (instr),
    .instr_addr_o       (instr_addr),
    .instr_compressed_o (instr_compressed)
  );

  fetch_mem_model u_mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_req_i    (bus_req),
    .bus_addr_i   (bus_addr),
    .bus_gnt_o    (bus_gnt),
    .bus_rvalid_o (bus_rvalid),
    .bus_rdata_o  (bus_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // Bus requests granted and not yet answered, old path included
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(bus_req && bus_gnt) - int'(bus_rvalid);
    end
  end

  //////////////////////////////
  // Monitor at the falling edge where inputs and outputs are settled
  //////////////////////////////

  always @(negedge clk) begin
    if (!rst_n) begin
      hold_pending = 1'b0;
    end else begin
      if (hold_pending && !pc_set) begin
        checks++;
        if (!instr_valid || instr !== held_instr || instr_addr !== held_addr ||
            instr_compressed !== held_comp) begin
          $display("[FAIL] %0t: instruction output changed while ready was low", $time);
          errors++;
        end
      end
      hold_pending = instr_valid && !instr_ready && !pc_set;
      held_instr   = instr;
      held_addr    = instr_addr;
      held_comp    = instr_compressed;
      // Valid and ready here means the DUT takes it at the next rising edge
      if (instr_valid && instr_ready) begin
        got_instr.push_back(instr);
        got_addr.push_back(instr_addr);
        got_comp.push_back(instr_compressed);
      end
    end
  end

  //////////////////////////////
  // Reference walk
  //////////////////////////////

  function automatic logic [15:0] half_at(input logic [31:0] addr);
    logic [31:0] word;
    word = image[addr[9:2]];
    return addr[1] ? word[31:16] : word[15:0];
  endfunction

  // Compares the first n accepted instructions with a walk from start
  task automatic check_stream(input logic [31:0] start, input int n);
    logic [31:0] addr;
    logic [31:0] exp_instr;
    logic [15:0] lo;
    logic        exp_comp;
    int          cnt;
    addr = start;
    cnt  = (got_addr.size() < n) ? got_addr.size() : n;
    for (int k = 0; k < cnt; k++) begin
      lo        = half_at(addr);
      exp_comp  = (lo[1:0] != 2'b11);
      exp_instr = exp_comp ? {16'h0000, lo} : {half_at(addr + 32'd2), lo};
      checks++;
      if (got_addr[k] !== addr || got_instr[k] !== exp_instr || got_comp[k] !== exp_comp) begin
        $display("[FAIL] %0t: instr %0d got %h at %h c=%b, expected %h at %h c=%b", $time, k,
                 got_instr[k], got_addr[k], got_comp[k], exp_instr, addr, exp_comp);
        errors++;
      end
      addr = addr + (exp_comp ? 32'd2 : 32'd4);
    end
  endtask

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic clear_stream();
    got_instr.delete();
    got_addr.delete();
    got_comp.delete();
  endtask

  task automatic apply_reset();
    rst_n       <= 1'b0;
    instr_req   <= 1'b0;
    pc_set      <= 1'b0;
    instr_ready <= 1'b1;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    clear_stream();
  endtask

  // Fill depends on the whole word index
  // Mixed code sets half the halfwords to open a 32-bit instruction
  task automatic load_image(input bit mixed);
    logic [31:0] rnd;
    logic [31:0] word;
    for (int i = 0; i < 256; i++) begin
      rnd  = $random(seed);
      word = (32'(i) * 32'h9e37_79b1) ^ rnd;
      if (mixed) begin
        word[1:0]   = rnd[4] ? 2'b11 : {1'b0, rnd[5]};
        word[17:16] = rnd[6] ? 2'b11 : {1'b0, rnd[7]};
      end else begin
        word[1:0] = 2'b11;
      end
      image[i]     = word;
      u_mem.mem[i] = word;
    end
  endtask

  task automatic collect(input int n, input int limit);
    int waited;
    waited = 0;
    while (got_addr.size() < n && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    if (got_addr.size() < n) begin
      $display("Only %0d of %0d instructions arrived within %0d cycles",
               got_addr.size(), n, limit);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
      $display("[ok]   %s", name);
    end else begin
      $display("[bad]  %s with %0d errors", name, errors - err0);
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_sequential();
    int err0;
    err0 = errors;
    apply_reset();
    load_image(1'b0);
    @(negedge clk);
    checks++;
    if (bus_req !== 1'b0 || instr_valid !== 1'b0) begin
      $display("[FAIL] %0t: bus request or instruction valid high after reset", $time);
      errors++;
    end
    @(posedge clk);
    instr_req <= 1'b1;
    collect(20, 400);
    check_stream(32'h0, 20);
    report_test("sequential 32-bit fetch", err0);
  endtask

  task automatic test_mixed();
    int err0;
    err0 = errors;
    apply_reset();
    load_image(1'b1);
    instr_req <= 1'b1;
    collect(40, 600);
    check_stream(32'h0, 40);
    report_test("mixed and straddling code", err0);
  endtask

  // The DUT ignores bit 0 of the target, which is set here on purpose
  task automatic test_idle_branch();
    int err0;
    err0 = errors;
    apply_reset();
    load_image(1'b1);
    repeat (4) @(posedge clk);
    pc_set      <= 1'b1;
    branch_addr <= 32'h0000_0053;
    instr_req   <= 1'b1;
    @(posedge clk);
    pc_set <= 1'b0;
    collect(24, 400);
    check_stream(32'h0000_0052, 24);
    report_test("branch to upper half at idle", err0);
  endtask

  task automatic test_busy_branch();
    int err0;
    int waited;
    int split;
    err0   = errors;
    waited = 0;
    apply_reset();
    load_image(1'b1);
    instr_req <= 1'b1;
    while (!(outstanding == 2 && instr_valid) && waited < 300) begin
      @(negedge clk);
      waited++;
    end
    if (!(outstanding == 2 && instr_valid)) begin
      $display("Two outstanding requests with a filled buffer were never reached");
      errors++;
    end
    @(posedge clk);
    pc_set      <= 1'b1;
    branch_addr <= 32'h0000_00a6;
    // Everything accepted up to this edge belongs to the old path
    split = got_addr.size();
    check_stream(32'h0, split);
    clear_stream();
    @(posedge clk);
    pc_set <= 1'b0;
    collect(30, 500);
    check_stream(32'h0000_00a6, 30);
    report_test("branch with requests in flight", err0);
  endtask

  task automatic test_backpressure();
    int          err0;
    int          waited;
    logic [31:0] rnd;
    err0   = errors;
    waited = 0;
    apply_reset();
    load_image(1'b1);
    instr_req <= 1'b1;
    while (got_addr.size() < 60 && waited < 1500) begin
      @(posedge clk);
      rnd = $random(seed);
      instr_ready <= rnd[0];
      waited++;
    end
    instr_ready <= 1'b1;
    if (got_addr.size() < 60) begin
      $display("Only %0d of 60 instructions arrived under back-pressure", got_addr.size());
      errors++;
    end
    check_stream(32'h0, 60);
    report_test("random back-pressure", err0);
  endtask

  initial begin
    seed         = 32'he5ad_749e;
    errors       = 0;
    checks       = 0;
    cycle_cnt    = 0;
    hold_pending = 1'b0;
    rst_n        = 1'b0;
    instr_req    = 1'b0;
    pc_set       = 1'b0;
    branch_addr  = '0;
    instr_ready  = 1'b0;
    test_sequential();
    test_mixed();
    test_idle_branch();
    test_busy_branch();
    test_backpressure();
    $display("Summary: 5 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== dv/fetch_mem_model.sv ====
//////////////////////////////
// Instruction memory model
// 256-word array, random grants, in-order responses
// after one to three cycles
//////////////////////////////

`timescale 1ns/1ps

module fetch_mem_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        bus_req_i,
  input  logic [31:0] bus_addr_i,
  output logic        bus_gnt_o,
  output logic        bus_rvalid_o,
  output logic [31:0] bus_rdata_o
);

  // Preloaded by the testbench through a hierarchical reference
  logic [31:0] mem [256];

  integer      seed;
  logic [31:0] rnd;
  logic [7:0]  pend_idx [$];
  int          pend_due [$];
  int          cycle_cnt;
  int          last_due;
  int          due;

  initial seed = 32'he5ad_749e;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus_gnt_o    <= 1'b0;
      bus_rvalid_o <= 1'b0;
      bus_rdata_o  <= '0;
      pend_idx.delete();
      pend_due.delete();
      cycle_cnt = 0;
      last_due  = -1;
    end else begin
      rnd = $random(seed);
      // A transfer takes place when request and grant meet at this edge
      if (bus_req_i && bus_gnt_o) begin
        due = cycle_cnt + (int'(rnd[9:8]) % 3);
        // Never two answers in one cycle, so the order is kept
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        pend_idx.push_back(bus_addr_i[9:2]);
        pend_due.push_back(due);
      end
      bus_rvalid_o <= 1'b0;
      if (pend_due.size() != 0 && pend_due[0] <= cycle_cnt) begin
        bus_rvalid_o <= 1'b1;
        bus_rdata_o  <= mem[pend_idx.pop_front()];
        void'(pend_due.pop_front());
      end
      // Grant offered in about three cycles out of four
      bus_gnt_o <= (rnd[1:0] != 2'b00);
      cycle_cnt = cycle_cnt + 1;
    end
  end

endmodule

// ==== source/fetch_unit.sv ====
//////////////////////////////
// Instruction fetch front end
// Prefetcher and alignment buffer wired together
//////////////////////////////

`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetch_unit (
  input  logic                      clk,
  input  logic                      rst_n,

  // Control from the core
  input  logic                      instr_req_i,
  input  logic                      pc_set_i,
  input  logic [`FETCH_ADDR_W-1:0]  branch_addr_i,

  // Instruction memory bus
  output logic                      bus_req_o,
  output logic [`FETCH_ADDR_W-1:0]  bus_addr_o,
  input  logic                      bus_gnt_i,
  input  logic                      bus_rvalid_i,
  input  logic [31:0]               bus_rdata_i,

  // Aligned instructions towards the core
  output logic                      instr_valid_o,
  input  logic                      instr_ready_i,
  output logic [31:0]               instr_o,
  output logic [`FETCH_ADDR_W-1:0]  instr_addr_o,
  output logic                      instr_compressed_o
);

  // Buffer to prefetcher request path
  logic                      fetch_valid;
  logic                      fetch_ready;
  logic                      fetch_branch;
  logic [`FETCH_ADDR_W-1:0]  fetch_branch_addr;

  // Prefetcher to buffer response path
  logic                      resp_valid;
  fetch_pkg::fetch_word_u    resp_data;

  prefetch_ctrl u_prefetch_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_valid_i       (fetch_valid),
    .fetch_ready_o       (fetch_ready),
    .fetch_branch_i      (fetch_branch),
    .fetch_branch_addr_i (fetch_branch_addr),
    .resp_valid_o        (resp_valid),
    .resp_data_o         (resp_data),
    .bus_req_o           (bus_req_o),
    .bus_addr_o          (bus_addr_o),
    .bus_gnt_i           (bus_gnt_i),
    .bus_rvalid_i        (bus_rvalid_i),
    .bus_rdata_i         (bus_rdata_i)
  );

  align_buffer u_align_buffer (
    .clk                 (clk),
    .rst_n               (rst_n),
    .instr_req_i         (instr_req_i),
    .pc_set_i            (pc_set_i),
    .branch_addr_i       (branch_addr_i),
    .fetch_valid_o       (fetch_valid),
    .fetch_ready_i       (fetch_ready),
    .fetch_branch_o      (fetch_branch),
    .fetch_branch_addr_o (fetch_branch_addr),
    .resp_valid_i        (resp_valid),
    .resp_data_i         (resp_data),
    .instr_valid_o       (instr_valid_o),
    .instr_ready_i       (instr_ready_i),
    .instr_o             (instr_o),
    .instr_addr_o        (instr_addr_o),
    .instr_compressed_o  (instr_compressed_o)
  );

endmodule

// ==== source/align_buffer.sv ====
//////////////////////////////
// Alignment buffer
// Three-entry word FIFO, halfword alignment of RV32IC instructions,
// outstanding and flush counting, fetch decision and branch handling
//////////////////////////////

`timescale 1ns/1ps

`include "fetch_defines.svh"

module align_buffer (
  input  logic                      clk,
  input  logic                      rst_n,

  // Control from the core
  input  logic                      instr_req_i,
  input  logic                      pc_set_i,
  input  logic [`FETCH_ADDR_W-1:0]  branch_addr_i,

  // Request side towards the prefetcher
  output logic                      fetch_valid_o,
  input  logic                      fetch_ready_i,
  output logic                      fetch_branch_o,
  output logic [`FETCH_ADDR_W-1:0]  fetch_branch_addr_o,

  // Response side from the prefetcher
  input  logic                      resp_valid_i,
  input  fetch_pkg::fetch_word_u    resp_data_i,

  // Instruction side towards the core
  output logic                      instr_valid_o,
  input  logic                      instr_ready_i,
  output logic [31:0]               instr_o,
  output logic [`FETCH_ADDR_W-1:0]  instr_addr_o,
  output logic                      instr_compressed_o
);

  localparam int ADDR_W = `FETCH_ADDR_W;
  localparam int DEPTH  = `ALBUF_DEPTH;
  localparam int PTR_W  = $clog2(DEPTH);
  localparam logic [PTR_W-1:0]  LAST_PTR  = PTR_W'(DEPTH - 1);
  localparam logic [2:0]        DEPTH_C   = 3'(DEPTH);
  localparam logic [2:0]        MAX_OUT_C = 3'(`MAX_OUTSTANDING);
  localparam logic [ADDR_W-1:0] STEP_HALF = ADDR_W'(2);
  localparam logic [ADDR_W-1:0] STEP_WORD = ADDR_W'(4);

  // FIFO storage and state
  fetch_pkg::fetch_word_u words_q [DEPTH];
  logic [DEPTH-1:0]       valid_q;
  logic [PTR_W-1:0]       wptr_q;
  logic [PTR_W-1:0]       rptr_q;
  logic [PTR_W-1:0]       rptr2;
  logic [2:0]             word_cnt;

  // Current instruction starts at the upper half of the read word
  logic                   offset_q;
  logic [ADDR_W-1:0]      addr_q;

  // Requests of the current path, and old-path requests still to be dropped
  logic [1:0]             outstanding_q;
  logic [1:0]             flush_q;
  logic [2:0]             fill_cnt;
  logic [2:0]             in_flight;

  logic                   issue;
  logic                   resp_flush;
  logic                   resp_keep;
  logic                   wr_en;
  logic                   accept;
  logic                   pop;

  // Alignment view of the two oldest words
  fetch_pkg::fetch_word_u cur_word;
  fetch_pkg::fetch_word_u nxt_word;
  fetch_pkg::fetch_word_u instr_word;
  logic [15:0]            sel_half;
  logic                   instr_compressed;

  //////////////////////////////
  // Fetch decision
  //////////////////////////////

  always_comb begin
    word_cnt = '0;
    for (int i = 0; i < DEPTH; i++) begin
      word_cnt = word_cnt + {2'b00, valid_q[i]};
    end
  end

  // Buffered words plus pending responses reserve FIFO space up front
  assign fill_cnt  = word_cnt + {1'b0, outstanding_q};
  assign in_flight = {1'b0, outstanding_q} + {1'b0, flush_q};

  // In the branch cycle the FIFO is being cleared, so only the bus limit counts
  always_comb begin
    if (pc_set_i) begin
      fetch_valid_o = instr_req_i && (in_flight < MAX_OUT_C);
    end else begin
      fetch_valid_o = instr_req_i && (fill_cnt < DEPTH_C) && (in_flight < MAX_OUT_C);
    end
  end

  assign fetch_branch_o      = pc_set_i;
  assign fetch_branch_addr_o = {branch_addr_i[ADDR_W-1:1], 1'b0};

  assign issue      = fetch_valid_o && fetch_ready_i;
  // Stale responses always arrive first since the bus answers in order
  assign resp_flush = resp_valid_i && (flush_q != 2'd0);
  assign resp_keep  = resp_valid_i && (flush_q == 2'd0);
  assign wr_en      = resp_keep && !pc_set_i;

  // On a branch every request of the old path moves to the flush count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
      flush_q       <= '0;
    end else if (pc_set_i) begin
      outstanding_q <= {1'b0, issue};
      flush_q       <= flush_q - {1'b0, resp_flush} + outstanding_q - {1'b0, resp_keep};
    end else begin
      outstanding_q <= outstanding_q + {1'b0, issue} - {1'b0, resp_keep};
      flush_q       <= flush_q - {1'b0, resp_flush};
    end
  end

  //////////////////////////////
  // Alignment
  //////////////////////////////

  assign rptr2    = (rptr_q == LAST_PTR) ? '0 : rptr_q + 1'b1;
  assign cur_word = words_q[rptr_q];
  assign nxt_word = words_q[rptr2];

  assign sel_half         = offset_q ? cur_word.half[1] : cur_word.half[0];
  assign instr_compressed = fetch_pkg::is_compressed(sel_half);

  // A 32-bit instruction at the upper half needs the lower half of the next word
  always_comb begin
    instr_word.word = cur_word.word;
    if (instr_compressed) begin
      instr_word.half[1] = '0;
      instr_word.half[0] = sel_half;
    end else if (offset_q) begin
      instr_word.half[1] = nxt_word.half[0];
      instr_word.half[0] = cur_word.half[1];
    end
  end

  assign instr_valid_o = valid_q[rptr_q] && !pc_set_i &&
                         (instr_compressed || !offset_q || valid_q[rptr2]);
  assign instr_o            = instr_word.word;
  assign instr_addr_o       = addr_q;
  assign instr_compressed_o = instr_compressed;

  assign accept = instr_valid_o && instr_ready_i;
  // The read word is done once its upper half has been consumed
  assign pop    = accept && (offset_q || !instr_compressed);

  //////////////////////////////
  // FIFO and address state
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      words_q[wptr_q] <= resp_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q  <= '0;
      wptr_q   <= '0;
      rptr_q   <= '0;
      offset_q <= 1'b0;
      addr_q   <= '0;
    end else if (pc_set_i) begin
      valid_q  <= '0;
      wptr_q   <= '0;
      rptr_q   <= '0;
      offset_q <= branch_addr_i[1];
      addr_q   <= {branch_addr_i[ADDR_W-1:1], 1'b0};
    end else begin
      if (wr_en) begin
        valid_q[wptr_q] <= 1'b1;
        wptr_q          <= (wptr_q == LAST_PTR) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        valid_q[rptr_q] <= 1'b0;
        rptr_q          <= rptr2;
      end
      if (accept) begin
        // Offset flips on a compressed instruction and holds on a 32-bit one
        offset_q <= offset_q ^ instr_compressed;
        addr_q   <= addr_q + (instr_compressed ? STEP_HALF : STEP_WORD);
      end
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  a_no_overwrite: assert property (
    @(posedge clk) disable iff (!rst_n) wr_en |-> !valid_q[wptr_q]
  ) else $error("Response written to an occupied FIFO entry");

  a_empty_after_branch: assert property (
    @(posedge clk) disable iff (!rst_n) pc_set_i |=> (valid_q == '0)
  ) else $error("FIFO not empty after a branch");

  a_no_valid_on_branch: assert property (
    @(posedge clk) disable iff (!rst_n) pc_set_i |-> !instr_valid_o
  ) else $error("Instruction offered in the branch cycle");

  a_max_outstanding: assert property (
    @(posedge clk) disable iff (!rst_n) in_flight <= MAX_OUT_C
  ) else $error("Too many bus requests in flight");

  a_ptr_range: assert property (
    @(posedge clk) disable iff (!rst_n) (wptr_q <= LAST_PTR) && (rptr_q <= LAST_PTR)
  ) else $error("FIFO pointer out of range");

endmodule

// ==== source/prefetch_ctrl.sv ====
//////////////////////////////
// Prefetch controller
// Word-aligned fetch address register, bus request and grant side,
// response forwarding to the alignment buffer
//////////////////////////////

`timescale 1ns/1ps

`include "fetch_defines.svh"

module prefetch_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,

  // Request side from the alignment buffer
  input  logic                      fetch_valid_i,
  output logic                      fetch_ready_o,
  input  logic                      fetch_branch_i,
  input  logic [`FETCH_ADDR_W-1:0]  fetch_branch_addr_i,

  // Response side towards the alignment buffer
  output logic                      resp_valid_o,
  output fetch_pkg::fetch_word_u    resp_data_o,

  // Instruction memory bus
  output logic                      bus_req_o,
  output logic [`FETCH_ADDR_W-1:0]  bus_addr_o,
  input  logic                      bus_gnt_i,
  input  logic                      bus_rvalid_i,
  input  logic [31:0]               bus_rdata_i
);

  localparam int ADDR_W = `FETCH_ADDR_W;
  localparam logic [ADDR_W-1:0] WORD_STEP = ADDR_W'(4);

  // Address of the next word to request, always word aligned
  logic [ADDR_W-1:0] addr_q;
  // Word address of the branch target, bits 1 and 0 cleared
  logic [ADDR_W-1:0] branch_word;
  // Address presented on the bus this cycle
  logic [ADDR_W-1:0] req_addr;
  // A request is handed to the bus in this cycle
  logic              granted;

  //////////////////////////////
  // Request side
  //////////////////////////////

  assign branch_word = {fetch_branch_addr_i[ADDR_W-1:2], 2'b00};

  // The branch target goes out in the branch cycle itself
  // so the new path costs no extra cycle
  assign req_addr = fetch_branch_i ? branch_word : addr_q;

  // The buffer decides when to fetch, also in the branch cycle
  assign bus_req_o     = fetch_valid_i;
  assign bus_addr_o    = req_addr;
  assign fetch_ready_o = bus_gnt_i;
  assign granted       = fetch_valid_i && bus_gnt_i;

  // On a branch the register takes the target, or the word after it
  // when the target is granted at once
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (fetch_branch_i) begin
      addr_q <= granted ? (branch_word + WORD_STEP) : branch_word;
    end else if (granted) begin
      addr_q <= addr_q + WORD_STEP;
    end
  end

  //////////////////////////////
  // Response side
  //////////////////////////////

  // Responses come back in order and the buffer sorts out stale ones
  assign resp_valid_o     = bus_rvalid_i;
  assign resp_data_o.word = bus_rdata_i;

  // A request waiting for its grant keeps its address, unless a branch
  // moves the fetch to a new target
  a_req_addr_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (bus_req_o && !bus_gnt_i) ##1 (bus_req_o && !fetch_branch_i)
    |-> $stable(bus_addr_o)
  ) else $error("Bus address changed while the request waited for a grant");

endmodule

// ==== source/fetch_pkg.sv ====
//////////////////////////////
// Fetch package
// Fetch word union and the compressed instruction test
//////////////////////////////

package fetch_pkg;

  // One 32-bit fetch word seen either whole or as two halfwords
  // The whole view serves a 32-bit instruction that starts at the low half
  // The halfword view serves the upper half and instructions that straddle
  // Index 0 of the halfword view is the lower half of the word
  typedef union packed {
    logic [31:0]       word;
    logic [1:0][15:0]  half;
  } fetch_word_u;

  // A halfword opens a compressed instruction unless its two low bits
  // are both one, which marks the start of a 32-bit instruction
  function automatic logic is_compressed(input logic [15:0] halfword);
    logic low_ones;
    low_ones = (halfword[1:0] == 2'b11);
    return !low_ones;
  endfunction

endpackage

// ==== source/fetch_defines.svh ====
//////////////////////////////
// Shared sizing macros for the instruction fetch front end
// Address width, alignment FIFO depth and outstanding request limit
//////////////////////////////

`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Width of every instruction and bus address
`define FETCH_ADDR_W 32

// Number of 32-bit word entries held by the alignment FIFO
// Three entries let a straddling instruction sit next to one more word
`define ALBUF_DEPTH 3

// Largest number of bus requests granted but not yet answered
// This counts requests of the current path and those being flushed
`define MAX_OUTSTANDING 2

`endif
